// ==== project.f ====
+incdir+verilog
+incdir+testbench
verilog/zc_seq_pkg.sv
verilog/zc_decoder.sv
verilog/zc_seq_ctrl.sv
verilog/zc_instr_gen.sv
verilog/zc_sequencer.sv
testbench/tb_zc_sequencer.sv

// ==== Makefile ====
# Verilator build and run of the sequencer testbench
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_zc_sequencer
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line appears in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_zc_tasks.svh ====
// Directed tests of the sequencer, included into the testbench module.
// Each task builds compressed words and runs them through drive_seq.
`ifndef TB_ZC_TASKS_SVH
`define TB_ZC_TASKS_SVH

// cm.push/pop/popret/popretz with sel in bits 12:8
function automatic logic [15:0] stack_cinstr(input logic [4:0] sel, input logic [3:0] rlist,
                                             input logic [1:0] spimm);
  return {3'b101, sel, rlist, spimm, 2'b10};
endfunction

// cm.mvsa01 (f = 01) and cm.mva01s (f = 11)
function automatic logic [15:0] move_cinstr(input logic [1:0] f, input logic [2:0] r1,
                                            input logic [2:0] r2);
  return {3'b101, 3'b011, r1, f, r2, 2'b10};
endfunction

// Every rlist and spimm of cm.push
task automatic push_sweep();
  int rl;
  int sp;
  for (rl = 4; rl <= 15; rl++) begin
    for (sp = 0; sp < 4; sp++) begin
      drive_seq($sformatf("push rlist %0d spimm %0d", rl, sp),
                stack_cinstr(5'b11000, 4'(rl), 2'(sp)), 0, -1, -1);
    end
  end
endtask

// pop, popret and popretz with random rlist and spimm
task automatic pop_random();
  logic [4:0] sel [3];
  logic [3:0] rl;
  logic [1:0] sp;
  int         k;
  int         i;
  sel[0] = 5'b11010;
  sel[1] = 5'b11110;
  sel[2] = 5'b11100;
  for (k = 0; k < 3; k++) begin
    for (i = 0; i < 8; i++) begin
      rl = 4'(4 + ({$random(seed)} % 12));
      sp = 2'($random(seed));
      drive_seq($sformatf("pop kind %0d rlist %0d spimm %0d", k, rl, sp),
                stack_cinstr(sel[k], rl, sp), 0, -1, -1);
    end
  end
endtask

// Both double moves with random distinct registers
task automatic move_random();
  logic [2:0] r1;
  logic [2:0] r2;
  int         i;
  for (i = 0; i < 6; i++) begin
    r1 = 3'($random(seed));
    r2 = 3'($random(seed));
    while (r2 == r1) begin
      r2 = 3'($random(seed));
    end
    drive_seq($sformatf("mvsa01 s%0d s%0d", r1, r2), move_cinstr(2'b01, r1, r2), 0, -1, -1);
    drive_seq($sformatf("mva01s s%0d s%0d", r1, r2), move_cinstr(2'b11, r1, r2), 0, -1, -1);
  end
endtask

// Illegal word held valid, outputs stay invalid and the word is dropped
task automatic check_invalid(input string name, input logic [15:0] c);
  @(negedge clk);
  instr_i = {16'h0000, c};
  valid_i = 1'b1;
  ready_i = 1'b1;
  repeat (2) begin
    #(clk_period / 4);
    check_value(name, "valid_o", 32'd0, 32'(valid_o));
    check_value(name, "ready_o", 32'd1, 32'(ready_o));
    @(negedge clk);
  end
  valid_i = 1'b0;
endtask

task automatic illegal_words();
  logic [2:0] r;
  int         rl;
  r = 3'($random(seed));
  check_invalid("mvsa01 equal regs", move_cinstr(2'b01, r, r));
  check_invalid("mva01s equal regs", move_cinstr(2'b11, r, r));
  for (rl = 0; rl < 4; rl++) begin
    check_invalid($sformatf("push rlist %0d", rl), stack_cinstr(5'b11000, 4'(rl), 2'd0));
  end
endtask

// ready_i dropped at random, same word must hold until accepted
task automatic backpressure_pop();
  int i;
  for (i = 0; i < 4; i++) begin
    drive_seq($sformatf("stalled popretz %0d", i),
              stack_cinstr(5'b11100, 4'(12 + i), 2'(i)), 40, -1, -1);
  end
endtask

task automatic halt_and_kill();
  // Halt before the fourth word, then resume
  drive_seq("halted popretz", stack_cinstr(5'b11100, 4'd10, 2'd1), 0, 3, -1);
  // Leave a push after two words and kill it
  drive_seq("killed push", stack_cinstr(5'b11000, 4'd8, 2'd0), 0, -1, 2);
  kill_i = 1'b1;
  #(clk_period / 4);
  check_value("killed push", "ready_o on kill", 32'd1, 32'(ready_o));
  check_value("killed push", "valid_o on kill", 32'd0, 32'(valid_o));
  @(negedge clk);
  kill_i  = 1'b0;
  // Push word stays valid but stalled, the step holds what the kill left
  ready_i = 1'b0;
  #(clk_period / 4);
  check_value("killed push", "seq_first_o after kill", 32'd1, 32'(seq_first_o));
  // Fresh start from the first word
  drive_seq("pop after kill", stack_cinstr(5'b11010, 4'd7, 2'd2), 0, -1, -1);
endtask

`endif

// ==== testbench/tb_zc_sequencer.sv ====
// Testbench for the compressed push/pop and double move sequencer.
// Drives compressed words, follows the handshake and compares every emitted
// base instruction and strobe with a model of the expected sequence.
// Directed tests live in the included task file.
`default_nettype none
`timescale 1ns/1ps

`include "zc_seq_cfg.svh"

module tb_zc_sequencer;

  localparam int clk_period = 40;
  // Upper bound on sequences run and on operations per sequence
  localparam int n_sequences = 100;
  localparam int max_ops = 16;
  // Margin of 4 covers stalls and idle cycles between sequences
  localparam int watchdog_ns = n_sequences * max_ops * 4 * clk_period + 40 * clk_period;

  // Base major opcodes
  localparam logic [6:0] opc_load  = 7'b0000011;
  localparam logic [6:0] opc_store = 7'b0100011;
  localparam logic [6:0] opc_opimm = 7'b0010011;
  localparam logic [6:0] opc_jalr  = 7'b1100111;

  logic        clk;
  logic        rst_n;
  logic [31:0] instr_i;
  logic        valid_i;
  logic        ready_i;
  logic        halt_i;
  logic        kill_i;
  logic [31:0] instr_o;
  logic        valid_o;
  logic        ready_o;
  logic        seq_first_o;
  logic        seq_last_o;

  integer      seed;
  int          errors;
  int          checks;
  // Expected words of the sequence under test
  logic [31:0] exp_q[$];

  zc_sequencer u_zc_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_i     (instr_i),
    .valid_i     (valid_i),
    .ready_o     (ready_o),
    .ready_i     (ready_i),
    .halt_i      (halt_i),
    .kill_i      (kill_i),
    .instr_o     (instr_o),
    .valid_o     (valid_o),
    .seq_first_o (seq_first_o),
    .seq_last_o  (seq_last_o)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //////////////////////////////
  // Expected-sequence model
  //////////////////////////////

  // I-type word, also used for loads and jalr
  function automatic logic [31:0] itype_word(input int imm, input int rs1, input logic [2:0] f3,
                                             input int rd, input logic [6:0] opc);
    return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
  endfunction

  // S-type word with the immediate split around rs2 and rs1
  function automatic logic [31:0] stype_word(input int imm, input int rs2, input int rs1,
                                             input logic [2:0] f3, input logic [6:0] opc);
    logic [11:0] im;
    im = 12'(imm);
    return {im[11:5], 5'(rs2), 5'(rs1), f3, im[4:0], opc};
  endfunction

  // s0/s1 are x8/x9, s2 and up continue from x18
  function automatic int s_reg_num(input int idx);
    return (idx < 2) ? 8 + idx : 18 + idx - 2;
  endfunction

  // Fills exp_q with the base words for one compressed word, empty if illegal
  function automatic void build_expected(input logic [15:0] c);
    int   rlist;
    int   rs;
    int   total;
    int   n;
    int   r1;
    int   r2;
    logic is_push;
    logic is_pop;
    logic is_ret;
    logic is_retz;
    exp_q.delete();
    if (c[1:0] != 2'b10 || c[15:13] != 3'b101) begin
      return;
    end
    // Double moves
    if (c[12:10] == 3'b011) begin
      r1 = s_reg_num(int'(c[9:7]));
      r2 = s_reg_num(int'(c[4:2]));
      if (c[9:7] == c[4:2]) begin
        return;
      end
      if (c[6:5] == 2'b01) begin
        exp_q.push_back(itype_word(0, `ZC_REG_A0, 3'b000, r1, opc_opimm));
        exp_q.push_back(itype_word(0, `ZC_REG_A1, 3'b000, r2, opc_opimm));
      end else if (c[6:5] == 2'b11) begin
        exp_q.push_back(itype_word(0, r1, 3'b000, `ZC_REG_A0, opc_opimm));
        exp_q.push_back(itype_word(0, r2, 3'b000, `ZC_REG_A1, opc_opimm));
      end
      return;
    end
    is_push = (c[12:8] == 5'b11000);
    is_pop  = (c[12:8] == 5'b11010);
    is_retz = (c[12:8] == 5'b11100);
    is_ret  = (c[12:8] == 5'b11110);
    rlist   = int'(c[7:4]);
    if (!(is_push || is_pop || is_ret || is_retz) || rlist < `ZC_RLIST_MIN) begin
      return;
    end
    rs    = (rlist == 15) ? 12 : rlist - 4;
    // s registers plus ra rounded to the alignment, then spimm blocks
    total = (((rs + 1) * 4 + `ZC_STACK_ALIGN - 1) / `ZC_STACK_ALIGN) * `ZC_STACK_ALIGN;
    total = total + int'(c[3:2]) * `ZC_STACK_ALIGN;
    // Highest s register first, ra in the slot after the last one
    for (n = 0; n <= rs; n++) begin
      r1 = (n < rs) ? s_reg_num(rs - 1 - n) : `ZC_REG_RA;
      if (is_push) begin
        exp_q.push_back(stype_word(-4 * (n + 1), r1, `ZC_REG_SP, 3'b010, opc_store));
      end else begin
        exp_q.push_back(itype_word(total - 4 * (n + 1), `ZC_REG_SP, 3'b010, r1, opc_load));
      end
    end
    exp_q.push_back(itype_word(is_push ? -total : total, `ZC_REG_SP, 3'b000, `ZC_REG_SP,
                               opc_opimm));
    if (is_retz) begin
      exp_q.push_back(itype_word(0, `ZC_REG_ZERO, 3'b000, `ZC_REG_A0, opc_opimm));
    end
    if (is_ret || is_retz) begin
      exp_q.push_back(itype_word(0, `ZC_REG_RA, 3'b000, `ZC_REG_ZERO, opc_jalr));
    end
  endfunction

  //////////////////////////////
  // Checking and driving
  //////////////////////////////

  task automatic check_value(input string name, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp)
    else begin
      errors++;
      $display("Error %s, %s: expected %h actual %h", name, what, exp, act);
    end
  endtask

  // Runs one compressed word through the DUT and checks each word and strobe.
  // halt_at halts before that word, stop_at leaves the word valid after that many
  task automatic drive_seq(input string name, input logic [15:0] c, input int stall_pct,
                           input int halt_at, input int stop_at);
    int          n;
    int          idx;
    int          idle_cycles;
    bit          halted;
    logic [31:0] rnd;
    build_expected(c);
    n           = exp_q.size();
    idx         = 0;
    idle_cycles = 0;
    halted      = 1'b0;
    @(negedge clk);
    rnd     = $random(seed);
    // Upper half is noise the DUT must ignore
    instr_i = {rnd[31:16], c};
    valid_i = 1'b1;
    halt_i  = 1'b0;
    kill_i  = 1'b0;
    while (idx < n && idx != stop_at) begin
      if (idx == halt_at && !halted) begin
        halted  = 1'b1;
        halt_i  = 1'b1;
        ready_i = 1'b1;
        repeat (3) begin
          #(clk_period / 4);
          check_value(name, "valid_o in halt", 32'd0, 32'(valid_o));
          check_value(name, "ready_o in halt", 32'd0, 32'(ready_o));
          @(negedge clk);
        end
        halt_i = 1'b0;
      end
      rnd     = $random(seed);
      ready_i = ((rnd % 100) >= 32'(stall_pct));
      #(clk_period / 4);
      if (!valid_o) begin
        idle_cycles++;
        if (idle_cycles > 20) begin
          errors++;
          $display("%s: valid_o stayed low for 20 cycles, sequence abandoned", name);
          idx = n;
        end
      end else begin
        idle_cycles = 0;
        check_value(name, "instr_o", exp_q[idx], instr_o);
        check_value(name, "seq_first_o", 32'(idx == 0), 32'(seq_first_o));
        check_value(name, "seq_last_o", 32'(idx == n - 1), 32'(seq_last_o));
        check_value(name, "ready_o", 32'(ready_i && idx == n - 1), 32'(ready_o));
        if (ready_i) begin
          idx++;
        end
      end
      @(negedge clk);
    end
    if (stop_at < 0) begin
      valid_i = 1'b0;
      ready_i = 1'b1;
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    seed    = 32'hab3d;
    errors  = 0;
    checks  = 0;
    rst_n   = 1'b0;
    instr_i = '0;
    valid_i = 1'b0;
    ready_i = 1'b1;
    halt_i  = 1'b0;
    kill_i  = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    #(clk_period / 4);
    // Idle after reset with no valid input
    check_value("reset", "valid_o", 32'd0, 32'(valid_o));
    check_value("reset", "seq_first_o", 32'd0, 32'(seq_first_o));
    check_value("reset", "seq_last_o", 32'd0, 32'(seq_last_o));
    push_sweep();
    pop_random();
    move_random();
    illegal_words();
    backpressure_pop();
    halt_and_kill();
    repeat (4) @(negedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  `include "tb_zc_tasks.svh"

endmodule

`default_nettype wire

// ==== verilog/zc_sequencer.sv ====
// Top level of the compressed push/pop and double move sequencer.
// Takes one compressed instruction in the low half of a word and emits its
// base instruction series, one word per accepted cycle.
`default_nettype none
`timescale 1ns/1ps

`include "zc_seq_cfg.svh"

module zc_sequencer import zc_seq_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  // Upstream side
  input  logic [`ZC_ILEN-1:0] instr_i,
  input  logic                valid_i,
  output logic                ready_o,
  // Downstream side
  input  logic                ready_i,
  input  logic                halt_i,
  input  logic                kill_i,
  output logic [`ZC_ILEN-1:0] instr_o,
  output logic                valid_o,
  output logic                seq_first_o,
  output logic                seq_last_o
);

  seq_decode_t decode;
  seq_step_t   step;

  // Decode of the compressed word
  zc_decoder u_zc_decoder (
    .instr_i  (instr_i),
    .decode_o (decode)
  );

  // Step tracking and handshake
  zc_seq_ctrl u_zc_seq_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .decode_i    (decode),
    .valid_i     (valid_i),
    .ready_i     (ready_i),
    .halt_i      (halt_i),
    .kill_i      (kill_i),
    .step_o      (step),
    .valid_o     (valid_o),
    .ready_o     (ready_o),
    .seq_first_o (seq_first_o),
    .seq_last_o  (seq_last_o)
  );

  // Base instruction for the current step
  zc_instr_gen u_zc_instr_gen (
    .decode_i (decode),
    .step_i   (step),
    .instr_o  (instr_o)
  );

endmodule

`default_nettype wire

// ==== verilog/zc_instr_gen.sv ====
// Instruction generator. Builds the 32-bit base instruction for the current
// step of a push, pop or double move from the decoded fields.
// Combinational, so the word follows the step with no added latency.
`default_nettype none
`timescale 1ns/1ps

`include "zc_seq_cfg.svh"

module zc_instr_gen import zc_seq_pkg::*; (
  input  seq_decode_t         decode_i,
  input  seq_step_t           step_i,
  output logic [`ZC_ILEN-1:0] instr_o
);

  localparam logic [`ZC_REG_W-1:0] xreg_zero = `ZC_REG_W'(`ZC_REG_ZERO);
  localparam logic [`ZC_REG_W-1:0] xreg_ra   = `ZC_REG_W'(`ZC_REG_RA);
  localparam logic [`ZC_REG_W-1:0] xreg_sp   = `ZC_REG_W'(`ZC_REG_SP);
  localparam logic [`ZC_REG_W-1:0] xreg_a0   = `ZC_REG_W'(`ZC_REG_A0);
  localparam logic [`ZC_REG_W-1:0] xreg_a1   = `ZC_REG_W'(`ZC_REG_A1);

  //////////////////////////////
  // Encoders
  //////////////////////////////

  // lw rd, imm(sp)
  function automatic logic [`ZC_ILEN-1:0] enc_load(input logic [`ZC_REG_W-1:0] rd,
                                                   input logic [`ZC_IMM_W-1:0] imm);
    return {imm, xreg_sp, 3'b010, rd, LOAD};
  endfunction

  // sw rs2, imm(sp), immediate split around the register fields
  function automatic logic [`ZC_ILEN-1:0] enc_store(input logic [`ZC_REG_W-1:0] rs2,
                                                    input logic [`ZC_IMM_W-1:0] imm);
    return {imm[11:5], rs2, xreg_sp, 3'b010, imm[4:0], STORE};
  endfunction

  // addi rd, rs1, imm
  function automatic logic [`ZC_ILEN-1:0] enc_addi(input logic [`ZC_REG_W-1:0] rd,
                                                   input logic [`ZC_REG_W-1:0] rs1,
                                                   input logic [`ZC_IMM_W-1:0] imm);
    return {imm, rs1, 3'b000, rd, OPIMM};
  endfunction

  logic                 is_push;
  logic                 is_pushpop;
  logic [`ZC_IMM_W-1:0] slot_bytes;
  logic [`ZC_IMM_W-1:0] stack_off;
  logic [3:0]           sreg_idx;
  logic [`ZC_REG_W-1:0] sreg_num;
  logic [`ZC_REG_W-1:0] mem_reg;
  logic [`ZC_REG_W-1:0] move_s1;
  logic [`ZC_REG_W-1:0] move_s2;
  logic [`ZC_ILEN-1:0]  mem_instr;
  logic                 sreg_phase;

  assign is_push    = (decode_i.op == PUSH);
  assign is_pushpop = is_push || (decode_i.op == POP) ||
                      (decode_i.op == POPRET) || (decode_i.op == POPRETZ);

  //////////////////////////////
  // Stack slot and register
  //////////////////////////////

  // Slot n sits 4(n+1) below the old sp
  assign slot_bytes = (`ZC_IMM_W'(step_i.cnt) + `ZC_IMM_W'(1)) * `ZC_IMM_W'(`ZC_WORD_BYTES);

  // Pops rewind by the full frame first
  assign stack_off = is_push ? -slot_bytes : decode_i.total_stack_adj - slot_bytes;

  // Highest s register goes first
  assign sreg_idx = decode_i.registers_saved - 4'(step_i.cnt) - 4'd1;
  assign sreg_num = sreg_to_xreg(sreg_idx);

  // IDLE emits an s register unless the list is ra only
  assign sreg_phase = (step_i.state == SREG) ||
                      (step_i.state == IDLE && decode_i.registers_saved != 4'd0);
  assign mem_reg    = sreg_phase ? sreg_num : xreg_ra;
  assign mem_instr  = is_push ? enc_store(mem_reg, stack_off) : enc_load(mem_reg, stack_off);

  assign move_s1 = sreg_to_xreg({1'b0, decode_i.move_r1});
  assign move_s2 = sreg_to_xreg({1'b0, decode_i.move_r2});

  //////////////////////////////
  // Word select
  //////////////////////////////
  always_comb begin
    // nop when nothing is sequenced
    instr_o = enc_addi(xreg_zero, xreg_zero, '0);
    case (step_i.state)
      IDLE: begin
        if (is_pushpop) begin
          instr_o = mem_instr;
        end else if (decode_i.op == MVSA01) begin
          instr_o = enc_addi(move_s1, xreg_a0, '0);
        end else if (decode_i.op == MVA01S) begin
          instr_o = enc_addi(xreg_a0, move_s1, '0);
        end
      end
      SREG, RA: begin
        instr_o = mem_instr;
      end
      SP: begin
        // Push lowers sp, pops raise it
        if (is_push) begin
          instr_o = enc_addi(xreg_sp, xreg_sp, -decode_i.total_stack_adj);
        end else begin
          instr_o = enc_addi(xreg_sp, xreg_sp, decode_i.total_stack_adj);
        end
      end
      A0: begin
        instr_o = enc_addi(xreg_a0, xreg_zero, '0);
      end
      RET: begin
        // jalr x0, 0(ra)
        instr_o = {12'h000, xreg_ra, 3'b000, xreg_zero, JALR};
      end
      DMOVE2: begin
        if (decode_i.op == MVSA01) begin
          instr_o = enc_addi(move_s2, xreg_a1, '0);
        end else begin
          instr_o = enc_addi(xreg_a1, move_s2, '0);
        end
      end
      default: begin
        instr_o = enc_addi(xreg_zero, xreg_zero, '0);
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/zc_seq_ctrl.sv ====
// Sequence controller. Holds the state and operation counter, steps on each
// accepted operation and forms the valid, ready, first and last strobes.
// Halt holds the step, kill or missing input returns it to IDLE.
`default_nettype none
`timescale 1ns/1ps

`include "zc_seq_cfg.svh"

module zc_seq_ctrl import zc_seq_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  seq_decode_t decode_i,
  input  logic        valid_i,
  input  logic        ready_i,
  input  logic        halt_i,
  input  logic        kill_i,
  output seq_step_t   step_o,
  output logic        valid_o,
  output logic        ready_o,
  output logic        seq_first_o,
  output logic        seq_last_o
);

  seq_step_t  step_q;
  seq_state_e state_n;
  logic       last_fsm;
  logic       is_pushpop;
  logic       is_move;
  logic       clear_step;
  logic       accept;

  assign is_pushpop = (decode_i.op == PUSH) || (decode_i.op == POP) ||
                      (decode_i.op == POPRET) || (decode_i.op == POPRETZ);
  assign is_move    = (decode_i.op == MVSA01) || (decode_i.op == MVA01S);

  //////////////////////////////
  // Strobes
  //////////////////////////////

  // Valid for any legal sequenced instruction, blocked by halt and kill
  assign valid_o = (decode_i.op != INVALID) && valid_i && !halt_i && !kill_i;
  assign accept  = valid_o && ready_i;

  // No output while not halted, or kill, restarts the sequence
  assign clear_step = (!valid_o && !halt_i) || kill_i;

  // Upstream word is consumed with the last operation, or dropped on clear
  assign ready_o = (last_fsm && ready_i && !halt_i) || clear_step;

  assign seq_first_o = valid_o && (step_q.state == IDLE);
  assign seq_last_o  = valid_o && last_fsm;

  assign step_o = step_q;

  //////////////////////////////
  // Next state
  //////////////////////////////
  always_comb begin
    state_n  = step_q.state;
    last_fsm = 1'b0;
    case (step_q.state)
      IDLE: begin
        // First operation goes out from IDLE
        if (is_pushpop) begin
          if (decode_i.registers_saved == 4'd0) begin
            state_n = SP;
          end else if (decode_i.registers_saved == 4'd1) begin
            state_n = RA;
          end else begin
            state_n = SREG;
          end
        end else if (is_move) begin
          state_n = DMOVE2;
        end
      end
      SREG: begin
        // Loop over the remaining s registers
        if (step_q.cnt == `ZC_CNT_W'(decode_i.registers_saved - 4'd1)) begin
          state_n = RA;
        end
      end
      RA: begin
        state_n = SP;
      end
      SP: begin
        if (decode_i.op == POPRETZ) begin
          state_n = A0;
        end else if (decode_i.op == POPRET) begin
          state_n = RET;
        end else begin
          state_n  = IDLE;
          last_fsm = 1'b1;
        end
      end
      A0: begin
        state_n = RET;
      end
      RET, DMOVE2: begin
        state_n  = IDLE;
        last_fsm = 1'b1;
      end
      default: begin
        state_n = IDLE;
      end
    endcase
  end

  //////////////////////////////
  // Step register
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q.state <= IDLE;
      step_q.cnt   <= '0;
    end else if (clear_step) begin
      step_q.state <= IDLE;
      step_q.cnt   <= '0;
    end else if (accept) begin
      step_q.state <= state_n;
      // Counter wraps to 0 after the last operation
      if (last_fsm) begin
        step_q.cnt <= '0;
      end else begin
        step_q.cnt <= step_q.cnt + `ZC_CNT_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/zc_decoder.sv ====
// Decoder for the sequenced compressed instructions in the low half of a word.
// Selects the operation, register count and stack adjustment for the controller
// and the instruction generator. Purely combinational.
`default_nettype none
`timescale 1ns/1ps

`include "zc_seq_cfg.svh"

module zc_decoder import zc_seq_pkg::*; (
  input  logic [`ZC_ILEN-1:0] instr_i,
  output seq_decode_t         decode_o
);

  localparam logic [3:0] rlist_min = 4'(`ZC_RLIST_MIN);
  localparam logic [3:0] rlist_max = 4'(`ZC_RLIST_MAX);
  localparam logic [3:0] sreg_max  = 4'(`ZC_SREG_MAX);
  localparam logic [`ZC_IMM_W-1:0] align_mask = `ZC_IMM_W'(`ZC_STACK_ALIGN - 1);

  logic [15:0]          cinstr;
  logic [3:0]           rlist;
  logic [1:0]           spimm;
  logic                 rlist_ok;
  seq_op_e              op;
  logic [3:0]           registers_saved;
  logic [`ZC_IMM_W-1:0] reg_bytes;
  logic [`ZC_IMM_W-1:0] stack_base;
  logic [`ZC_IMM_W-1:0] total_stack_adj;

  // Only the low half carries the compressed instruction
  assign cinstr   = instr_i[15:0];
  assign rlist    = cinstr[7:4];
  assign spimm    = cinstr[3:2];
  assign rlist_ok = (rlist >= rlist_min);

  //////////////////////////////
  // Operation select
  //////////////////////////////
  always_comb begin
    op = INVALID;
    // Quadrant C2, funct3 101
    if (cinstr[1:0] == 2'b10 && cinstr[15:13] == 3'b101) begin
      case (cinstr[12:10])
        3'b011: begin
          // Double moves need two different s registers
          if (cinstr[9:7] != cinstr[4:2]) begin
            if (cinstr[6:5] == 2'b01) begin
              op = MVSA01;
            end else if (cinstr[6:5] == 2'b11) begin
              op = MVA01S;
            end
          end
        end
        3'b110: begin
          if (rlist_ok && cinstr[9:8] == 2'b00) begin
            op = PUSH;
          end else if (rlist_ok && cinstr[9:8] == 2'b10) begin
            op = POP;
          end
        end
        3'b111: begin
          if (rlist_ok && cinstr[9:8] == 2'b00) begin
            op = POPRETZ;
          end else if (rlist_ok && cinstr[9:8] == 2'b10) begin
            op = POPRET;
          end
        end
        default: begin
          op = INVALID;
        end
      endcase
    end
  end

  //////////////////////////////
  // Register count and stack
  //////////////////////////////

  // rlist 4 is ra only, 15 jumps to s0..s11
  always_comb begin
    if (rlist == rlist_max) begin
      registers_saved = sreg_max;
    end else if (rlist_ok) begin
      registers_saved = rlist - rlist_min;
    end else begin
      registers_saved = 4'd0;
    end
  end

  // Bytes for the s registers plus ra, rounded up to the stack alignment
  assign reg_bytes  = (`ZC_IMM_W'(registers_saved) + `ZC_IMM_W'(1)) * `ZC_IMM_W'(`ZC_WORD_BYTES);
  assign stack_base = (reg_bytes + align_mask) & ~align_mask;

  // Extra 16-byte blocks from spimm
  assign total_stack_adj = stack_base + `ZC_IMM_W'(spimm) * `ZC_IMM_W'(`ZC_STACK_ALIGN);

  always_comb begin
    decode_o.op              = op;
    decode_o.registers_saved = registers_saved;
    decode_o.total_stack_adj = total_stack_adj;
    decode_o.spimm           = spimm;
    // r1s' and r2s' of the double moves
    decode_o.move_r1         = cinstr[9:7];
    decode_o.move_r2         = cinstr[4:2];
  end

endmodule

`default_nettype wire

// ==== verilog/zc_seq_pkg.sv ====
// Shared types of the sequencer: operation, state and opcode enums,
// the decode and step structs, and the s-register to x-register mapping.
`default_nettype none

`include "zc_seq_cfg.svh"

package zc_seq_pkg;

  //////////////////////////////
  // Enums
  //////////////////////////////

  // Decoded sequenced instruction
  typedef enum logic [2:0] {
    INVALID,
    PUSH,
    POP,
    POPRET,
    POPRETZ,
    MVSA01,
    MVA01S
  } seq_op_e;

  // Controller states, SREG serves both push and pop loops
  typedef enum logic [2:0] {
    IDLE,
    SREG,
    RA,
    SP,
    A0,
    RET,
    DMOVE2
  } seq_state_e;

  // Base major opcodes emitted by the generator
  typedef enum logic [6:0] {
    LOAD  = 7'b0000011,
    OPIMM = 7'b0010011,
    STORE = 7'b0100011,
    JALR  = 7'b1100111
  } rv_opcode_e;

  //////////////////////////////
  // Structs
  //////////////////////////////

  // Metadata of the current compressed instruction
  typedef struct packed {
    seq_op_e               op;
    logic [3:0]            registers_saved;
    logic [`ZC_IMM_W-1:0]  total_stack_adj;
    logic [1:0]            spimm;
    logic [2:0]            move_r1;
    logic [2:0]            move_r2;
  } seq_decode_t;

  // Current controller step
  typedef struct packed {
    seq_state_e            state;
    logic [`ZC_CNT_W-1:0]  cnt;
  } seq_step_t;

  // s-register index to architectural register number
  function automatic logic [`ZC_REG_W-1:0] sreg_to_xreg(input logic [3:0] sidx);
    logic [`ZC_REG_W-1:0] xreg;
    if (sidx < 4'd2) begin
      xreg = `ZC_REG_W'(`ZC_REG_S0) + `ZC_REG_W'(sidx);
    end else begin
      xreg = `ZC_REG_W'(`ZC_REG_S2) + `ZC_REG_W'(sidx - 4'd2);
    end
    return xreg;
  endfunction

endpackage

`default_nettype wire

// ==== verilog/zc_seq_cfg.svh ====
// Configuration constants for the compressed push/pop and double move sequencer.
// Included by the package and by every RTL file that sizes ports or fields.
`ifndef ZC_SEQ_CFG_SVH
`define ZC_SEQ_CFG_SVH

//////////////////////////////
// Widths
//////////////////////////////

// Instruction word and operation counter
`define ZC_ILEN 32
`define ZC_CNT_W 4
// I-type and S-type immediate
`define ZC_IMM_W 12
// Register number field
`define ZC_REG_W 5

//////////////////////////////
// Register numbers
//////////////////////////////

`define ZC_REG_ZERO 0
`define ZC_REG_RA 1
`define ZC_REG_SP 2
`define ZC_REG_A0 10
`define ZC_REG_A1 11
// s0 and s1 sit at x8/x9, s2 and up start at x18
`define ZC_REG_S0 8
`define ZC_REG_S2 18

//////////////////////////////
// Stack constants
//////////////////////////////

`define ZC_WORD_BYTES 4
`define ZC_STACK_ALIGN 16
`define ZC_RLIST_MIN 4
`define ZC_RLIST_MAX 15
// rlist 15 saves s0..s11
`define ZC_SREG_MAX 12

`endif
